// File: rtl/spn_macros.svh
`ifndef SPN_MACROS_SVH
`define SPN_MACROS_SVH

// lanes carried side by side in one beat
`define SPN_LANES 8

// beats per frame and words per lane memory
`define SPN_STEPS 8

// sample width in bits
`define SPN_DATA_W 16

`endif

// File: rtl/spn_data_pkg.sv
`default_nettype none

`include "spn_macros.svh"

package spn_data_pkg;

    // one lane sample
    typedef logic [`SPN_DATA_W-1:0] sample_t;

    // lane 0 sits in the low bits
    typedef sample_t [`SPN_LANES-1:0] lanes_t;

    // one transfer on the stream
    // valid high means the lanes carry a frame step
    typedef struct packed {
        logic   valid;
        lanes_t lanes;
    } beat_t;

endpackage

`default_nettype wire

// File: rtl/spn_sched_pkg.sv
`default_nettype none

`include "spn_macros.svh"

package spn_sched_pkg;

    localparam int STEP_W = $clog2(`SPN_STEPS);
    localparam int LANE_W = $clog2(`SPN_LANES);

    typedef logic [STEP_W-1:0] step_t;
    typedef logic [LANE_W-1:0] lane_idx_t;
    typedef logic [STEP_W-1:0] ram_addr_t;

    // last step of a frame, where counters wrap
    localparam step_t LAST_STEP = step_t'(`SPN_STEPS - 1);

    // rotate schedule, output lane takes (lane + step) mod lanes
    function automatic lane_idx_t rot_src(lane_idx_t lane, step_t step);
        return lane_idx_t'(lane + lane_idx_t'(step));
    endfunction

    // xor schedule, output lane takes lane ^ step
    function automatic lane_idx_t xor_src(lane_idx_t lane, step_t step);
        return lane ^ lane_idx_t'(step);
    endfunction

    // even frames walk the memory in order
    // odd frames scramble the address by the lane number
    function automatic ram_addr_t lane_addr(step_t step, lane_idx_t lane, logic odd_frame);
        ram_addr_t base;
        base = ram_addr_t'(step);
        if (odd_frame) begin
            return base ^ ram_addr_t'(lane);
        end
        return base;
    endfunction

endpackage

`default_nettype wire

// File: rtl/lane_ram.sv
`default_nettype none

`include "spn_macros.svh"

module lane_ram (
    input  wire logic                      clk,
    input  wire logic                      wen,
    input  wire spn_sched_pkg::ram_addr_t  addr,
    input  wire spn_data_pkg::sample_t     din,
    output spn_data_pkg::sample_t          dout
);

    // one word per frame step
    spn_data_pkg::sample_t mem [`SPN_STEPS];

    // read-before-write
    // dout carries the word that was at addr before this edge
    always_ff @(posedge clk) begin
        dout <= mem[addr];
        if (wen) begin
            mem[addr] <= din;
        end
    end

endmodule

`default_nettype wire

// File: rtl/spatial_perm.sv
`default_nettype none

`include "spn_macros.svh"

module spatial_perm #(
    // 0 rotates the lanes by the step, 1 xors the lane index with the step
    parameter bit xor_mode = 1'b0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire spn_data_pkg::beat_t  in_beat,
    output spn_data_pkg::beat_t       out_beat
);

    spn_sched_pkg::step_t  step;
    spn_data_pkg::lanes_t  mapped;
    spn_data_pkg::lanes_t  lanes_q;
    logic                  valid_q;

    // crossbar select for every output lane at the current step
    always_comb begin
        spn_sched_pkg::lane_idx_t src;
        for (int i = 0; i < `SPN_LANES; i++) begin
            if (xor_mode) begin
                src = spn_sched_pkg::xor_src(spn_sched_pkg::lane_idx_t'(i), step);
            end else begin
                src = spn_sched_pkg::rot_src(spn_sched_pkg::lane_idx_t'(i), step);
            end
            mapped[i] = in_beat.lanes[src];
        end
    end

    // step advances on valid beats only so idle gaps keep the schedule
    always_ff @(posedge clk) begin
        if (rst) begin
            step    <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_beat.valid;
            if (in_beat.valid) begin
                if (step == spn_sched_pkg::LAST_STEP) begin
                    step <= '0;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // lanes hold their last beat through gaps
    always_ff @(posedge clk) begin
        if (in_beat.valid) begin
            lanes_q <= mapped;
        end
    end

    always_comb begin
        out_beat.valid = valid_q;
        out_beat.lanes = lanes_q;
    end

    // every accepted beat leaves one cycle later and nothing else does
    a_valid_delay: assert property (
        @(posedge clk) disable iff (rst)
        $past(!rst) |-> (out_beat.valid == $past(in_beat.valid))
    ) else $error("spatial_perm output valid is not input valid delayed by one cycle");

endmodule

`default_nettype wire

// File: rtl/temporal_perm.sv
`default_nettype none

`include "spn_macros.svh"

module temporal_perm (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire spn_data_pkg::beat_t  in_beat,
    output spn_data_pkg::beat_t       out_beat
);

    spn_sched_pkg::step_t                       step;
    logic                                       odd_frame;
    spn_sched_pkg::ram_addr_t [`SPN_LANES-1:0]  addr;
    spn_data_pkg::lanes_t                       rd_lanes;
    logic                                       valid_q;

    // step and frame parity follow valid beats only
    always_ff @(posedge clk) begin
        if (rst) begin
            step      <= '0;
            odd_frame <= 1'b0;
        end else if (in_beat.valid) begin
            if (step == spn_sched_pkg::LAST_STEP) begin
                step      <= '0;
                odd_frame <= ~odd_frame;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // per-lane address for this step
    always_comb begin
        for (int l = 0; l < `SPN_LANES; l++) begin
            addr[l] = spn_sched_pkg::lane_addr(
                step,
                spn_sched_pkg::lane_idx_t'(l),
                odd_frame
            );
        end
    end

    // the read returns the word written at step (c ^ l) of the previous frame
    for (genvar l = 0; l < `SPN_LANES; l++) begin : g_lane
        lane_ram u_ram (
            .clk  (clk),
            .wen  (in_beat.valid),
            .addr (addr[l]),
            .din  (in_beat.lanes[l]),
            .dout (rd_lanes[l])
        );
    end

    // valid travels with the registered memory read
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_beat.valid;
        end
    end

    always_comb begin
        out_beat.valid = valid_q;
        out_beat.lanes = rd_lanes;
    end

    // the address scramble may only switch between frames
    a_parity_flip: assert property (
        @(posedge clk) disable iff (rst)
        $changed(odd_frame) |-> $past(in_beat.valid && (step == spn_sched_pkg::LAST_STEP))
    ) else $error("temporal_perm frame parity changed away from a frame boundary");

endmodule

`default_nettype wire

// File: rtl/spn_top.sv
`default_nettype none

module spn_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire spn_data_pkg::beat_t  in_beat,
    output spn_data_pkg::beat_t       out_beat
);

    // stage 0 to temporal stage
    spn_data_pkg::beat_t s0_beat;

    // temporal stage to stage 2
    spn_data_pkg::beat_t s1_beat;

    // three registered stages, 3 cycles from in_beat to out_beat

    // lane i takes lane (i + c) mod 8
    spatial_perm #(
        .xor_mode (1'b0)
    ) stage0 (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (in_beat),
        .out_beat (s0_beat)
    );

    // lane memories, one frame of delay through the buffer
    temporal_perm stage1 (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (s0_beat),
        .out_beat (s1_beat)
    );

    // lane i takes lane i ^ c
    spatial_perm #(
        .xor_mode (1'b1)
    ) stage2 (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (s1_beat),
        .out_beat (out_beat)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`default_nettype none

module tb_clock #(
    // full clock period in time units
    parameter int period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: verif/spn_tb.sv
`default_nettype none

`include "spn_macros.svh"

module spn_tb;

    localparam int N_FRAMES   = 6;
    localparam int PIPE_DEPTH = 3;
    localparam int MARGIN     = 20;

    typedef enum logic [1:0] {
        FILL_COUNT,
        FILL_CONST,
        FILL_RAND
    } fill_t;

    // one row per frame
    // gap_mask bit s puts gap_len idle cycles before step s
    // check set means this frame's output data is compared
    typedef struct packed {
        fill_t       fill;
        logic [15:0] base;
        logic [7:0]  gap_mask;
        logic [3:0]  gap_len;
        logic        check;
    } frame_row_t;

    logic                   clk;
    logic                   rst;
    spn_data_pkg::beat_t    in_beat;
    spn_data_pkg::beat_t    out_beat;

    frame_row_t             frame_table [N_FRAMES];
    spn_data_pkg::sample_t  in_frames [N_FRAMES][`SPN_STEPS][`SPN_LANES];
    logic [31:0]            rng_state;
    logic [PIPE_DEPTH-1:0]  valid_hist;
    int                     out_count;
    int                     cycle_count;
    int                     timeout_limit;
    logic                   stream_on;

    tb_clock #(
        .period (4)
    ) clk_gen (
        .clk (clk)
    );

    spn_top UUT (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (in_beat),
        .out_beat (out_beat)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic load_table();
        // flush frame output is stale memory
        frame_table[0] = '{FILL_COUNT, 16'h0000, 8'h00, 4'd0, 1'b0};
        frame_table[1] = '{FILL_COUNT, 16'h1000, 8'h00, 4'd0, 1'b1};
        frame_table[2] = '{FILL_RAND,  16'h0000, 8'h00, 4'd0, 1'b1};
        frame_table[3] = '{FILL_RAND,  16'h0000, 8'ha5, 4'd2, 1'b1};
        frame_table[4] = '{FILL_CONST, 16'hbeef, 8'h3c, 4'd1, 1'b1};
        frame_table[5] = '{FILL_COUNT, 16'h5000, 8'h81, 4'd3, 1'b1};
    endtask

    task automatic build_frames();
        frame_row_t row;
        for (int f = 0; f < N_FRAMES; f++) begin
            row = frame_table[f];
            for (int s = 0; s < `SPN_STEPS; s++) begin
                for (int l = 0; l < `SPN_LANES; l++) begin
                    case (row.fill)
                        FILL_COUNT: begin
                            in_frames[f][s][l] = row.base + 16'(s * 16 + l);
                        end
                        FILL_CONST: begin
                            in_frames[f][s][l] = row.base;
                        end
                        default: begin
                            rng_state = xorshift32(rng_state);
                            in_frames[f][s][l] = rng_state[15:0];
                        end
                    endcase
                end
            end
        end
    endtask

    function automatic int total_gaps();
        int sum;
        sum = 0;
        for (int f = 0; f < N_FRAMES; f++) begin
            sum += $countones(frame_table[f].gap_mask) * int'(frame_table[f].gap_len);
        end
        return sum;
    endfunction

    // stage 2 takes lane k = i ^ c
    // memory returns step s = c ^ k of the previous frame
    // stage 0 had put input lane (k + s) mod 8 into lane k
    function automatic spn_data_pkg::sample_t predict_lane(int prev, int c, int i);
        int k;
        int s;
        int src;
        k = i ^ c;
        s = c ^ k;
        src = (k + s) % `SPN_LANES;
        return in_frames[prev][s][src];
    endfunction

    task automatic check_output_beat();
        int    fo;
        int    c;
        string name;
        fo = out_count / `SPN_STEPS;
        c = out_count % `SPN_STEPS;
        if (fo < N_FRAMES && frame_table[fo].check) begin
            for (int i = 0; i < `SPN_LANES; i++) begin
                name = $sformatf("out_beat.lanes[%0d] (frame %0d step %0d)", i, fo, c);
                check_value(name, 32'(out_beat.lanes[i]), 32'(predict_lane(fo - 1, c, i)));
            end
        end
        out_count++;
    endtask

    // check what the DUT shows then drive the next input
    task automatic step_cycle(input spn_data_pkg::beat_t drive);
        @(negedge clk);
        check_value("out_beat.valid", 32'(out_beat.valid), 32'(valid_hist[PIPE_DEPTH-1]));
        if (out_beat.valid) begin
            check_output_beat();
        end
        valid_hist = {valid_hist[PIPE_DEPTH-2:0], drive.valid};
        in_beat = drive;
    endtask

    task automatic send_frame(input int f);
        spn_data_pkg::beat_t beat;
        spn_data_pkg::beat_t idle;
        idle = '0;
        for (int s = 0; s < `SPN_STEPS; s++) begin
            if (frame_table[f].gap_mask[s]) begin
                repeat (frame_table[f].gap_len) begin
                    step_cycle(idle);
                end
            end
            beat.valid = 1'b1;
            for (int l = 0; l < `SPN_LANES; l++) begin
                beat.lanes[l] = in_frames[f][s][l];
            end
            step_cycle(beat);
        end
    endtask

    // hang guard counting from the first beat
    always @(posedge clk) begin
        if (stream_on) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > timeout_limit) begin
                $display("Timeout: the stream did not finish within %0d cycles", timeout_limit);
                $display("Something failed");
                $fatal(1);
            end
        end
    end

    initial begin
        spn_data_pkg::beat_t idle;
        idle = '0;
        rst = 1'b1;
        in_beat = '0;
        valid_hist = '0;
        out_count = 0;
        cycle_count = 0;
        stream_on = 1'b0;
        rng_state = 32'hfe1e6dce;
        load_table();
        build_frames();
        timeout_limit = N_FRAMES * `SPN_STEPS + total_gaps() + PIPE_DEPTH + MARGIN;

        repeat (8) @(negedge clk);
        rst = 1'b0;

        // output must stay quiet before any input
        repeat (4) begin
            step_cycle(idle);
        end

        stream_on = 1'b1;
        for (int f = 0; f < N_FRAMES; f++) begin
            send_frame(f);
        end

        // drain the pipeline and watch for stray beats
        repeat (PIPE_DEPTH + 3) begin
            step_cycle(idle);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: spn_top.f
+incdir+rtl
rtl/spn_data_pkg.sv
rtl/spn_sched_pkg.sv
rtl/lane_ram.sv
rtl/spatial_perm.sv
rtl/temporal_perm.sv
rtl/spn_top.sv
verif/tb_clock.sv
verif/spn_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module spn_tb -f spn_top.f -o spn_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/spn_sim > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
